//--- bench/mp3_mem_asserts.sv
`timescale 1ns/1ps

module mp3_mem_asserts (
    input logic                     i_clk,
    input logic                     i_arst_n,
    input lc3b_types::lc3b_pmem_req i_l2_req,   // Request on the memory side
    input logic                     i_l2_resp,
    input logic                     i_i_resp,   // Resp routed to the instruction cache
    input logic                     i_d_resp    // Resp routed to the data cache
);
    import lc3b_types::*;

    int violations = 0;                         // Read by the testbench at the end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Physical port rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_no_rd_wr: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_l2_req.read && i_l2_req.write))
        else begin
            violations++;
            $error("Memory request has read and write together");
        end

    a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_l2_req.read || i_l2_req.write) && !i_l2_resp |=> $stable(i_l2_req))
        else begin
            violations++;
            $error("Memory request changed before resp");
        end

    // A routed resp needs a granted request that is still active
    a_grant: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_i_resp || i_d_resp) |-> (i_l2_req.read || i_l2_req.write))
        else begin
            violations++;
            $error("Cache resp without an active grant");
        end

endmodule : mp3_mem_asserts

bind arbiter mp3_mem_asserts u_asserts (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_l2_req  (o_l2_req),
    .i_l2_resp (i_l2_resp),
    .i_i_resp  (o_i_pmem_resp),
    .i_d_resp  (o_d_pmem_resp)
);

//--- bench/pmem_model.sv
`timescale 1ns/1ps

module pmem_model (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  lc3b_types::lc3b_pmem_req i_req,        // Granted request from the arbiter
    output logic                     o_resp,       // One-cycle pulse
    output lc3b_types::lc3b_mem_data o_rdata,      // Line for a fill
    output int                       o_reads,      // Completed line reads
    output int                       o_writes      // Completed line writes
);
    import lc3b_types::*;

    localparam int LATENCY = 4;                    // Cycles before resp

    logic [15:0] mem [0:32767];                    // Word array, index is byte address >> 1
    int          wait_cnt;
    logic [14:0] base;                             // First word of the line

    assign base = i_req.address[15:1];

    // Word at byte address A holds A ^ 16'h5A5A
    initial begin
        for (int i = 0; i < 32768; i++) begin
            mem[i] = 16'(i * 2) ^ 16'h5A5A;
        end
    end

    always @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_resp   <= 1'b0;
            o_rdata  <= '0;
            wait_cnt <= 0;
            o_reads  <= 0;
            o_writes <= 0;
        end else if (o_resp) begin
            o_resp   <= 1'b0;                      // Request drops after the pulse
            wait_cnt <= 0;
        end else if (i_req.read || i_req.write) begin
            if (wait_cnt == LATENCY - 1) begin
                o_resp <= 1'b1;
                if (i_req.write) begin
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        mem[base + 15'(w)] <= i_req.wdata[16*w +: 16];
                    end
                    o_writes <= o_writes + 1;
                end else begin
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        o_rdata[16*w +: 16] <= mem[base + 15'(w)];
                    end
                    o_reads <= o_reads + 1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else begin
            wait_cnt <= 0;
        end
    end

endmodule : pmem_model

//--- bench/tb_mp3_mem.sv
`timescale 1ns/1ps

module tb_mp3_mem;
    import lc3b_types::*;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_ACCESSES = 19;                      // CPU accesses over all tests
    localparam int WATCHDOG_CYC = NUM_ACCESSES * 20 + 100; // Worst-case miss plus margin
    localparam int ACCESS_LIMIT = 40;                      // Cycles one access may wait

    logic         clk;
    logic         arst_n;
    lc3b_mem_req  instr_req;
    lc3b_mem_req  data_req;
    logic         instr_resp;
    logic         data_resp;
    lc3b_word     instr_rdata;
    lc3b_word     data_rdata;
    logic         pmem_resp;
    lc3b_mem_data pmem_rdata;
    lc3b_pmem_req pmem_req;
    int           rd_count;
    int           wr_count;

    logic [15:0]  shadow [0:32767];        // Expected memory image, word index
    logic [31:0]  lfsr_state;
    int           err_value;
    int           err_count;
    int           err_other;

    lc3b_word     log_addr  [$];           // Physical transfers in completion order
    bit           log_write [$];
    lc3b_mem_data log_line  [$];

    mp3_mem UUT (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_instr_req   (instr_req),
        .i_data_req    (data_req),
        .o_instr_resp  (instr_resp),
        .o_instr_rdata (instr_rdata),
        .o_data_resp   (data_resp),
        .o_data_rdata  (data_rdata),
        .i_pmem_resp   (pmem_resp),
        .i_pmem_rdata  (pmem_rdata),
        .o_pmem_req    (pmem_req)
    );

    pmem_model u_pmem (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_req    (pmem_req),
        .o_resp   (pmem_resp),
        .o_rdata  (pmem_rdata),
        .o_reads  (rd_count),
        .o_writes (wr_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, monitor, watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(negedge clk) begin
        if (arst_n && pmem_resp) begin     // Record each finished transfer
            log_addr.push_back(pmem_req.address);
            log_write.push_back(pmem_req.write);
            log_line.push_back(pmem_req.wdata);
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'hD000_0001;  // Galois taps 32,31,29,1
        end
        return b;
    endfunction

    function automatic lc3b_word rand_bits(input int n);
        lc3b_word v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic lc3b_mem_req make_req(input logic wr, input lc3b_word addr,
                                             input lc3b_mem_wmask mask, input lc3b_word d);
        lc3b_mem_req r;
        r.read        = !wr;
        r.write       = wr;
        r.byte_enable = mask;
        r.address     = addr;
        r.wdata       = d;
        return r;
    endfunction

    task automatic check_word(input string name, input lc3b_word exp, input lc3b_word act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            err_value++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    // One access, started 1 ns after a rising edge, ends at the same point
    task automatic cpu_access(input bit dport, input lc3b_mem_req req,
                              output lc3b_word rdata, output int waits);
        bit done;
        waits = 0;
        done  = 0;
        rdata = '0;
        if (dport) begin
            data_req = req;
        end else begin
            instr_req = req;
        end
        while (!done) begin
            @(negedge clk);                               // Outputs settled here
            if (dport ? data_resp : instr_resp) begin
                rdata = dport ? data_rdata : instr_rdata;
                done  = 1;
            end else begin
                waits++;
                if (waits > ACCESS_LIMIT) begin
                    $display("Access to %h got no response in time", req.address);
                    err_other++;
                    done = 1;
                end
            end
        end
        @(posedge clk);
        #1;
        if (dport) begin
            data_req = '0;
        end else begin
            instr_req = '0;
        end
    endtask

    task automatic read_check(input string name, input bit dport, input lc3b_word addr,
                              output int waits);
        lc3b_word rd;
        cpu_access(dport, make_req(1'b0, addr, 2'b00, '0), rd, waits);
        check_word(name, shadow[addr[15:1]], rd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_read_miss();
        int rd0;
        int w;
        rd0 = rd_count;
        read_check("miss instr 0102", 1'b0, 16'h0102, w);
        check_count("miss instr reads", rd0 + 1, rd_count);
        read_check("miss data 0236", 1'b1, 16'h0236, w);
        check_count("miss data reads", rd0 + 2, rd_count);
        check_count("miss writes", 0, wr_count);
    endtask

    task automatic test_read_hit();
        int rd0;
        int wr0;
        int w;
        rd0 = rd_count;
        wr0 = wr_count;
        read_check("hit instr 0104", 1'b0, 16'h0104, w);
        check_count("hit instr waits", 0, w);               // Resp in the request cycle
        read_check("hit data 0230", 1'b1, 16'h0230, w);
        check_count("hit data waits", 0, w);
        check_count("hit reads", rd0, rd_count);
        check_count("hit writes", wr0, wr_count);
    endtask

    task automatic test_write_merge();
        lc3b_word      addr;
        lc3b_word      d;
        lc3b_word      rd;
        lc3b_mem_wmask m;
        int            w;
        for (int k = 0; k < 4; k++) begin
            addr = 16'h0230 + 16'(2 * k);
            m    = lc3b_mem_wmask'(rand_bits(2));
            d    = rand_bits(16);
            cpu_access(1'b1, make_req(1'b1, addr, m, d), rd, w);
            if (m[0]) begin
                shadow[addr[15:1]][7:0] = d[7:0];
            end
            if (m[1]) begin
                shadow[addr[15:1]][15:8] = d[15:8];
            end
        end
        for (int k = 0; k < 4; k++) begin
            read_check("merge readback", 1'b1, 16'h0230 + 16'(2 * k), w);
        end
        check_count("merge writes", 0, wr_count);
    endtask

    task automatic test_evict();
        int rd0;
        int wr0;
        int w;
        rd0 = rd_count;
        wr0 = wr_count;
        log_addr.delete();
        log_write.delete();
        log_line.delete();
        read_check("evict new 1232", 1'b1, 16'h1232, w);    // Same set 3, new tag
        check_count("evict writes", wr0 + 1, wr_count);
        check_count("evict reads", rd0 + 1, rd_count);
        check_count("evict transfers", 2, log_addr.size());
        if (log_addr.size() == 2) begin
            check_count("evict first is write", 1, int'(log_write[0]));
            check_word("evict write addr", 16'h0230, log_addr[0]);
            check_count("evict second is read", 0, int'(log_write[1]));
            check_word("evict read addr", 16'h1230, log_addr[1]);
            for (int k = 0; k < LINE_WORDS; k++) begin
                check_word("evict line data", shadow[15'h0118 + 15'(k)],
                           log_line[0][16*k +: 16]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            read_check("evict reread", 1'b1, 16'h0230 + 16'(2 * k), w);
        end
    endtask

    task automatic test_dual_miss();
        int rd0;
        int wi;
        int wd;
        rd0 = rd_count;
        log_addr.delete();
        log_write.delete();
        log_line.delete();
        fork
            read_check("dual instr 0454", 1'b0, 16'h0454, wi);
            read_check("dual data 0668", 1'b1, 16'h0668, wd);
        join
        check_count("dual reads", rd0 + 2, rd_count);
        check_count("dual transfers", 2, log_addr.size());
        if (log_addr.size() == 2) begin
            check_word("dual first addr", 16'h0660, log_addr[0]);  // Data wins
            check_word("dual second addr", 16'h0450, log_addr[1]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int total;
        arst_n     = 1'b0;
        instr_req  = '0;
        data_req   = '0;
        lfsr_state = 32'ha937_7676;
        err_value  = 0;
        err_count  = 0;
        err_other  = 0;
        for (int i = 0; i < 32768; i++) begin
            shadow[i] = 16'(i * 2) ^ 16'h5A5A;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_read_miss();
        test_read_hit();
        test_write_merge();
        test_evict();
        test_dual_miss();

        repeat (2) @(posedge clk);
        err_other = err_other + UUT.u_arbiter.u_asserts.violations;
        total     = err_value + err_count + err_other;
        $display("Totals: %0d value errors, %0d count errors, %0d other failures",
                 err_value, err_count, err_other);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_mp3_mem

//--- hdl/arbiter.sv
`timescale 1ns/1ps

module arbiter (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  lc3b_types::lc3b_pmem_req i_i_pmem_req,   // From instruction cache
    input  lc3b_types::lc3b_pmem_req i_d_pmem_req,   // From data cache
    input  logic                     i_l2_resp,      // Memory side pulse
    input  lc3b_types::lc3b_mem_data i_l2_rdata,
    output logic                     o_i_pmem_resp,
    output logic                     o_d_pmem_resp,
    output lc3b_types::lc3b_mem_data o_rdata,        // Shared by both caches
    output lc3b_types::lc3b_pmem_req o_l2_req        // Granted request
);
    import lc3b_types::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    arb_state_t state;
    arb_state_t state_nxt;

    logic i_pending;
    logic d_pending;

    assign i_pending = i_i_pmem_req.read | i_i_pmem_req.write;
    assign d_pending = i_d_pmem_req.read | i_d_pmem_req.write;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Routing follows the grant
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt     = state;
        o_l2_req      = '0;  // Nothing on memory without a grant
        o_i_pmem_resp = 1'b0;
        o_d_pmem_resp = 1'b0;

        unique case (state)
            ARB_IDLE: begin
                if (d_pending) begin
                    state_nxt = ARB_DATA;   // Data side has priority
                end else if (i_pending) begin
                    state_nxt = ARB_INSTR;
                end
            end

            ARB_INSTR: begin
                o_l2_req      = i_i_pmem_req;
                o_i_pmem_resp = i_l2_resp;
                if (i_l2_resp) begin
                    state_nxt = ARB_IDLE;   // One transfer per grant
                end
            end

            ARB_DATA: begin
                o_l2_req      = i_d_pmem_req;
                o_d_pmem_resp = i_l2_resp;
                if (i_l2_resp) begin
                    state_nxt = ARB_IDLE;
                end
            end

            default: begin
                state_nxt = ARB_IDLE;
            end
        endcase
    end

    // Only the owner sees resp, so the other cache ignores this line
    assign o_rdata = i_l2_rdata;

endmodule : arbiter

//--- hdl/l1_cache.sv
`timescale 1ns/1ps

module l1_cache (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  lc3b_types::lc3b_mem_req  i_req,         // CPU port
    input  logic                     i_pmem_resp,   // Pulse from arbiter
    input  lc3b_types::lc3b_mem_data i_pmem_rdata,  // Fill line
    output logic                     o_mem_resp,    // One-cycle pulse per access
    output lc3b_types::lc3b_word     o_mem_rdata,
    output lc3b_types::lc3b_pmem_req o_pmem_req     // Toward arbiter
);
    import lc3b_types::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cache_state_t state;
    cache_state_t state_nxt;

    logic         req_active;  // Read or write pending
    logic         hit;
    logic         dirty;
    logic         load_line;
    logic         write_word;
    lc3b_word     evict_addr;
    lc3b_mem_data evict_line;
    lc3b_word     fill_addr;   // Line base of the request

    assign req_active = i_req.read | i_req.write;
    assign fill_addr  = {i_req.address[15:4], 4'b0000};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arrays and hit logic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    l1_cache_datapath u_datapath (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_req),
        .i_pmem_rdata (i_pmem_rdata),
        .i_load_line  (load_line),
        .i_write_word (write_word),
        .o_hit        (hit),
        .o_dirty      (dirty),
        .o_rdata      (o_mem_rdata),
        .o_evict_addr (evict_addr),
        .o_evict_line (evict_line)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= CHECK;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state and outputs
    always_comb begin
        state_nxt  = state;
        o_mem_resp = 1'b0;
        write_word = 1'b0;
        load_line  = 1'b0;
        o_pmem_req = '0;  // Idle physical port

        unique case (state)
            CHECK: begin
                if (req_active) begin
                    if (hit) begin
                        o_mem_resp = 1'b1;         // Zero wait hit
                        write_word = i_req.write;  // Store lands at this edge
                    end else if (dirty) begin
                        state_nxt = WRITEBACK;     // Victim first
                    end else begin
                        state_nxt = FILL;
                    end
                end
            end

            WRITEBACK: begin
                o_pmem_req.write   = 1'b1;
                o_pmem_req.address = evict_addr;  // Old tag, same set
                o_pmem_req.wdata   = evict_line;
                if (i_pmem_resp) begin
                    state_nxt = FILL;
                end
            end

            FILL: begin
                o_pmem_req.read    = 1'b1;
                o_pmem_req.address = fill_addr;
                if (i_pmem_resp) begin
                    load_line = 1'b1;      // Line valid, clean
                    state_nxt = CHECK;     // Hit answers next cycle
                end
            end

            default: begin
                state_nxt = CHECK;
            end
        endcase
    end

endmodule : l1_cache

//--- hdl/l1_cache_datapath.sv
`timescale 1ns/1ps

module l1_cache_datapath (
    input  logic                     i_clk,
    input  logic                     i_arst_n,
    input  lc3b_types::lc3b_mem_req  i_req,         // CPU request, selects the set
    input  lc3b_types::lc3b_mem_data i_pmem_rdata,  // Line from the arbiter
    input  logic                     i_load_line,   // Install fetched line
    input  logic                     i_write_word,  // Merge write data into line
    output logic                     o_hit,
    output logic                     o_dirty,       // Victim needs writeback
    output lc3b_types::lc3b_word     o_rdata,
    output lc3b_types::lc3b_word     o_evict_addr,  // Line address of the victim
    output lc3b_types::lc3b_mem_data o_evict_line
);
    import lc3b_types::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    lc3b_tag      req_tag;
    lc3b_index    req_index;
    lc3b_offset   req_offset;

    // Storage arrays
    lc3b_tag             tag_arr  [NUM_SETS];
    lc3b_mem_data        data_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid_arr;
    logic [NUM_SETS-1:0] dirty_arr;

    lc3b_mem_data cur_line;     // Line at the requested set
    lc3b_mem_data merged_line;  // Line with write bytes applied

    assign req_tag    = i_req.address[15:7];
    assign req_index  = i_req.address[6:4];
    assign req_offset = i_req.address[3:1];  // Bit 0 picks the byte, not used here

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign cur_line     = data_arr[req_index];
    assign o_hit        = valid_arr[req_index] && (tag_arr[req_index] == req_tag);
    assign o_dirty      = valid_arr[req_index] && dirty_arr[req_index];
    assign o_rdata      = cur_line[req_offset*16 +: 16];                // Word select
    assign o_evict_addr = {tag_arr[req_index], req_index, 4'b0000};    // Old line base
    assign o_evict_line = cur_line;

    // Byte merge of the write word into its slot
    always_comb begin
        merged_line = cur_line;
        for (int w = 0; w < LINE_WORDS; w++) begin
            if (lc3b_offset'(w) == req_offset) begin
                if (i_req.byte_enable[0]) begin
                    merged_line[16*w +: 8] = i_req.wdata[7:0];     // Low byte
                end
                if (i_req.byte_enable[1]) begin
                    merged_line[16*w+8 +: 8] = i_req.wdata[15:8];  // High byte
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array updates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Tag and data payload
    always_ff @(posedge i_clk) begin
        if (i_load_line) begin
            data_arr[req_index] <= i_pmem_rdata;  // Fresh line from memory
            tag_arr[req_index]  <= req_tag;
        end else if (i_write_word) begin
            data_arr[req_index] <= merged_line;   // Write hit
        end
    end

    // Valid and dirty bits
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (i_load_line) begin
            valid_arr[req_index] <= 1'b1;
            dirty_arr[req_index] <= 1'b0;  // Matches memory after fill
        end else if (i_write_word) begin
            dirty_arr[req_index] <= 1'b1;  // Line now differs from memory
        end
    end

endmodule : l1_cache_datapath

//--- hdl/lc3b_types.sv
package lc3b_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_SETS   = 8;                 // Direct-mapped, one line per set
    localparam int LINE_WORDS = 8;                 // 16-bit words per 16-byte line

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0]                    lc3b_word;       // Address or data word
    typedef logic [16*LINE_WORDS-1:0]       lc3b_mem_data;   // One full cache line
    typedef logic [1:0]                     lc3b_mem_wmask;  // Byte enables, bit 1 is high byte
    typedef logic [8:0]                     lc3b_tag;        // Address bits 15..7
    typedef logic [$clog2(NUM_SETS)-1:0]    lc3b_index;      // Address bits 6..4
    typedef logic [$clog2(LINE_WORDS)-1:0]  lc3b_offset;     // Address bits 3..1

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // CPU side request, held by the requester until mem_resp
    typedef struct packed {
        logic          read;         // Read strobe level
        logic          write;        // Write strobe level
        lc3b_mem_wmask byte_enable;  // Used on writes only
        lc3b_word      address;      // Byte address
        lc3b_word      wdata;        // Write word
    } lc3b_mem_req;

    // Physical side request, one whole line per transfer
    typedef struct packed {
        logic          read;         // Line fill
        logic          write;        // Line writeback
        lc3b_word      address;      // Line address, low nibble zero
        lc3b_mem_data  wdata;        // Evicted line
    } lc3b_pmem_req;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // L1 controller
    typedef enum logic [1:0] {
        CHECK,      // Tag lookup, hits answer here
        WRITEBACK,  // Dirty victim goes out
        FILL        // New line comes in
    } cache_state_t;

    // Physical port owner
    typedef enum logic [1:0] {
        ARB_IDLE,   // No grant
        ARB_INSTR,  // Instruction cache owns memory
        ARB_DATA    // Data cache owns memory
    } arb_state_t;

endpackage : lc3b_types

//--- hdl/mp3_mem.sv
`timescale 1ns/1ps

module mp3_mem (
    input  logic                     i_clk,
    input  logic                     i_arst_n,

    // CPU ports
    input  lc3b_types::lc3b_mem_req  i_instr_req,
    input  lc3b_types::lc3b_mem_req  i_data_req,
    output logic                     o_instr_resp,
    output lc3b_types::lc3b_word     o_instr_rdata,
    output logic                     o_data_resp,
    output lc3b_types::lc3b_word     o_data_rdata,

    // Physical memory port
    input  logic                     i_pmem_resp,
    input  lc3b_types::lc3b_mem_data i_pmem_rdata,
    output lc3b_types::lc3b_pmem_req o_pmem_req
);
    import lc3b_types::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache to arbiter wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    lc3b_pmem_req ic_pmem_req;   // Instruction cache miss traffic
    lc3b_pmem_req dc_pmem_req;   // Data cache miss traffic
    logic         ic_pmem_resp;
    logic         dc_pmem_resp;
    lc3b_mem_data arb_rdata;     // Fill line to both caches

    l1_cache i_cache (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_instr_req),
        .i_pmem_resp  (ic_pmem_resp),
        .i_pmem_rdata (arb_rdata),
        .o_mem_resp   (o_instr_resp),
        .o_mem_rdata  (o_instr_rdata),
        .o_pmem_req   (ic_pmem_req)
    );

    l1_cache d_cache (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_data_req),
        .i_pmem_resp  (dc_pmem_resp),
        .i_pmem_rdata (arb_rdata),
        .o_mem_resp   (o_data_resp),
        .o_mem_rdata  (o_data_rdata),
        .o_pmem_req   (dc_pmem_req)
    );

    // Single physical port, data misses first
    arbiter u_arbiter (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_i_pmem_req  (ic_pmem_req),
        .i_d_pmem_req  (dc_pmem_req),
        .i_l2_resp     (i_pmem_resp),
        .i_l2_rdata    (i_pmem_rdata),
        .o_i_pmem_resp (ic_pmem_resp),
        .o_d_pmem_resp (dc_pmem_resp),
        .o_rdata       (arb_rdata),
        .o_l2_req      (o_pmem_req)
    );

endmodule : mp3_mem

//--- tb.f
hdl/lc3b_types.sv
hdl/l1_cache_datapath.sv
hdl/l1_cache.sv
hdl/arbiter.sv
hdl/mp3_mem.sv
bench/pmem_model.sv
bench/mp3_mem_asserts.sv
bench/tb_mp3_mem.sv
